//--- design/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_store,
    input  logic [`DC_ADDR_W-1:0] req_addr,
    input  mem_size_t             req_size,
    input  logic                  req_signed,
    input  logic [`DC_WORD_W-1:0] req_data,
    output logic                  resp_valid,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output logic                  mem_req_store,
    output logic [`DC_ADDR_W-1:0] mem_req_addr,
    output mem_size_t             mem_req_size,
    output logic [`DC_WORD_W-1:0] mem_req_data,
    input  logic                  mem_resp_valid,
    output logic [`DC_ADDR_W-1:0] lookup_addr,
    input  logic                  hit,
    input  logic [`DC_WAY_W-1:0]  hit_way,
    input  logic [`DC_WAY_W-1:0]  repl_way,
    output logic                  fill_en,
    output logic [`DC_WAY_W-1:0]  fill_way,
    output logic                  merge_en,
    output logic                  plru_update_en,
    output logic [`DC_WAY_W-1:0]  plru_update_way,
    output logic [`DC_ADDR_W-1:0] align_addr,
    output mem_size_t             align_size,
    output logic                  align_signed
);

    localparam logic [1:0] IDLE    = 2'd0;
    localparam logic [1:0] FETCH   = 2'd1;
    localparam logic [1:0] WAIT    = 2'd2;
    localparam logic [1:0] RESPOND = 2'd3;

    logic [1:0] state;
    logic [1:0] state_next;

    // Load being served
    logic [`DC_ADDR_W-1:0] load_addr;
    mem_size_t             load_size;
    logic                  load_signed;
    logic [`DC_WAY_W-1:0]  line_way;

    logic store_req;
    logic load_accept;
    logic store_accept;
    logic fill_done;

    assign store_req    = req_valid && req_store;
    assign load_accept  = req_valid && !req_store && (state == IDLE || state == RESPOND);
    assign store_accept = store_req && (state == IDLE) && mem_req_ready;
    assign fill_done    = (state == WAIT) && mem_resp_valid;

    // Stores go straight to memory, so memory back-pressure reaches the requester.
    // The data array is busy reading the response in RESPOND, so stores wait a cycle.
    always_comb begin
        case (state)
            IDLE:    req_ready = !store_req || mem_req_ready;
            RESPOND: req_ready = !store_req;
            default: req_ready = 1'b0;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE, RESPOND: begin
                if (load_accept) begin
                    state_next = hit ? RESPOND : FETCH;
                end else begin
                    state_next = IDLE;
                end
            end
            FETCH: begin
                if (mem_req_ready) begin
                    state_next = WAIT;
                end
            end
            default: begin
                if (mem_resp_valid) begin
                    state_next = RESPOND;
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Nothing touches valid bits or PLRU before the fill, so repl_way stays good
    always_ff @(posedge clock) begin
        if (load_accept) begin
            load_addr   <= req_addr;
            load_size   <= req_size;
            load_signed <= req_signed;
            line_way    <= hit ? hit_way : repl_way;
        end
    end

    assign lookup_addr = (state == FETCH || state == WAIT) ? load_addr : req_addr;

    assign mem_req_valid = (state == FETCH) || ((state == IDLE) && store_req);
    assign mem_req_store = (state != FETCH);
    assign mem_req_addr  = (state == FETCH) ?
                           {load_addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}} :
                           req_addr;
    assign mem_req_size  = (state == FETCH) ? DOUBLE : req_size;
    assign mem_req_data  = (state == FETCH) ? '0 : req_data;

    assign fill_en  = fill_done;
    assign fill_way = line_way;
    assign merge_en = store_accept && hit;

    assign plru_update_en  = ((load_accept || store_accept) && hit) || fill_done;
    assign plru_update_way = fill_done ? line_way : hit_way;

    assign resp_valid   = (state == RESPOND);
    assign align_addr   = load_addr;
    assign align_size   = load_size;
    assign align_signed = load_signed;

    a_mem_req_stable: assert property (
        @(posedge clock) disable iff (reset)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_req_store) && $stable(mem_req_addr) &&
            $stable(mem_req_size) && $stable(mem_req_data)
    ) else $error("Memory request changed while stalled");

endmodule

`default_nettype wire

//--- design/dcache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_data_array import dcache_pkg::*; (
    input  logic                    clock,
    input  logic [`DC_SET_W-1:0]    set,
    input  logic [`DC_WAY_W-1:0]    way,
    output cache_line_t             read_line,
    input  logic                    fill_en,
    input  logic [`DC_LINE_W-1:0]   fill_line,
    input  logic                    merge_en,
    input  logic [`DC_OFFSET_W-1:0] merge_offset,
    input  mem_size_t               merge_size,
    input  logic [`DC_WORD_W-1:0]   merge_data
);

    cache_line_t lines [`DC_SETS][`DC_WAYS];

    assign read_line = lines[set][way];

    always_ff @(posedge clock) begin
        if (fill_en) begin
            lines[set][way] <= fill_line;
        end else if (merge_en) begin
            // Store hit patches only the written bytes
            case (merge_size)
                BYTE: begin
                    lines[set][way].bytes[merge_offset] <= merge_data[7:0];
                end
                HALF: begin
                    lines[set][way].halves[merge_offset[`DC_OFFSET_W-1:1]] <= merge_data[15:0];
                end
                default: begin
                    lines[set][way].words[merge_offset[`DC_OFFSET_W-1]] <= merge_data;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/dcache_pkg.sv
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    // DOUBLE only appears on line fetches
    typedef enum logic [1:0] {
        BYTE   = 2'd0,
        HALF   = 2'd1,
        WORD   = 2'd2,
        DOUBLE = 2'd3
    } mem_size_t;

    // One cache line, seen at three granularities
    typedef union packed {
        logic [`DC_LINE_W/`DC_WORD_W-1:0][`DC_WORD_W-1:0] words;
        logic [`DC_LINE_W/16-1:0][15:0]                   halves;
        logic [`DC_LINE_W/8-1:0][7:0]                     bytes;
    } cache_line_t;

endpackage

`default_nettype wire

//--- design/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Address split is tag | set | offset
`define DC_ADDR_W   16
`define DC_OFFSET_W 3
`define DC_SET_W    3
`define DC_SETS     8
`define DC_WAYS     4
`define DC_WAY_W    2
`define DC_TAG_W    10

`define DC_LINE_W   64
`define DC_WORD_W   32

`endif

//--- design/dcache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_tag_array (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [`DC_ADDR_W-1:0] lookup_addr,
    output logic                  hit,
    output logic [`DC_WAY_W-1:0]  hit_way,
    output logic [`DC_WAY_W-1:0]  repl_way,
    input  logic [`DC_WAY_W-1:0]  plru_way,
    input  logic                  fill_en,
    input  logic [`DC_WAY_W-1:0]  fill_way
);

    logic [`DC_TAG_W-1:0] tags  [`DC_SETS][`DC_WAYS];
    logic [`DC_WAYS-1:0]  valid [`DC_SETS];

    logic [`DC_SET_W-1:0] set;
    logic [`DC_TAG_W-1:0] tag;
    logic [`DC_WAYS-1:0]  match;

    assign set = lookup_addr[`DC_OFFSET_W +: `DC_SET_W];
    assign tag = lookup_addr[`DC_ADDR_W-1 -: `DC_TAG_W];

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            match[w] = valid[set][w] && (tags[set][w] == tag);
        end
    end

    assign hit = |match;

    always_comb begin
        hit_way = '0;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = `DC_WAY_W'(w);
            end
        end
    end

    // Lowest invalid way wins over the PLRU choice
    always_comb begin
        repl_way = plru_way;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!valid[set][w]) begin
                repl_way = `DC_WAY_W'(w);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (fill_en) begin
            valid[set][fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_en) begin
            tags[set][fill_way] <= tag;
        end
    end

    a_single_match: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0(match)
    ) else $error("Tag matches in more than one way");

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_top import dcache_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  req_store,
    input  logic [`DC_ADDR_W-1:0] req_addr,
    input  mem_size_t             req_size,
    input  logic                  req_signed,
    input  logic [`DC_WORD_W-1:0] req_data,
    output logic                  resp_valid,
    output logic [`DC_WORD_W-1:0] resp_data,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output logic                  mem_req_store,
    output logic [`DC_ADDR_W-1:0] mem_req_addr,
    output mem_size_t             mem_req_size,
    output logic [`DC_WORD_W-1:0] mem_req_data,
    input  logic                  mem_resp_valid,
    input  logic [`DC_LINE_W-1:0] mem_resp_data
);

    logic [`DC_ADDR_W-1:0] lookup_addr;
    logic [`DC_ADDR_W-1:0] align_addr;
    mem_size_t             align_size;
    logic                  align_signed;
    logic                  hit;
    logic [`DC_WAY_W-1:0]  hit_way;
    logic [`DC_WAY_W-1:0]  repl_way;
    logic [`DC_WAY_W-1:0]  plru_way;
    logic                  fill_en;
    logic [`DC_WAY_W-1:0]  fill_way;
    logic                  merge_en;
    logic                  plru_update_en;
    logic [`DC_WAY_W-1:0]  plru_update_way;
    logic [`DC_SET_W-1:0]  lookup_set;
    logic [`DC_SET_W-1:0]  data_set;
    logic [`DC_WAY_W-1:0]  data_way;
    cache_line_t           read_line;

    assign lookup_set = lookup_addr[`DC_OFFSET_W +: `DC_SET_W];

    // Store merges hit the incoming request; otherwise the held load line
    assign data_set = merge_en ? lookup_set : align_addr[`DC_OFFSET_W +: `DC_SET_W];
    assign data_way = merge_en ? hit_way : fill_way;

    dcache_ctrl ctrl0 (
        .clock           (clock),
        .reset           (reset),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_store       (req_store),
        .req_addr        (req_addr),
        .req_size        (req_size),
        .req_signed      (req_signed),
        .req_data        (req_data),
        .resp_valid      (resp_valid),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_req_store   (mem_req_store),
        .mem_req_addr    (mem_req_addr),
        .mem_req_size    (mem_req_size),
        .mem_req_data    (mem_req_data),
        .mem_resp_valid  (mem_resp_valid),
        .lookup_addr     (lookup_addr),
        .hit             (hit),
        .hit_way         (hit_way),
        .repl_way        (repl_way),
        .fill_en         (fill_en),
        .fill_way        (fill_way),
        .merge_en        (merge_en),
        .plru_update_en  (plru_update_en),
        .plru_update_way (plru_update_way),
        .align_addr      (align_addr),
        .align_size      (align_size),
        .align_signed    (align_signed)
    );

    tree_plru plru0 (
        .clock      (clock),
        .reset      (reset),
        .lookup_set (lookup_set),
        .victim_way (plru_way),
        .update_en  (plru_update_en),
        .update_set (lookup_set),
        .update_way (plru_update_way)
    );

    dcache_tag_array tags0 (
        .clock       (clock),
        .reset       (reset),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_way     (hit_way),
        .repl_way    (repl_way),
        .plru_way    (plru_way),
        .fill_en     (fill_en),
        .fill_way    (fill_way)
    );

    dcache_data_array data0 (
        .clock        (clock),
        .set          (data_set),
        .way          (data_way),
        .read_line    (read_line),
        .fill_en      (fill_en),
        .fill_line    (mem_resp_data),
        .merge_en     (merge_en),
        .merge_offset (lookup_addr[`DC_OFFSET_W-1:0]),
        .merge_size   (req_size),
        .merge_data   (req_data)
    );

    load_align align0 (
        .line      (read_line),
        .offset    (align_addr[`DC_OFFSET_W-1:0]),
        .size      (align_size),
        .is_signed (align_signed),
        .value     (resp_data)
    );

endmodule

`default_nettype wire

//--- design/load_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module load_align import dcache_pkg::*; (
    input  cache_line_t             line,
    input  logic [`DC_OFFSET_W-1:0] offset,
    input  mem_size_t               size,
    input  logic                    is_signed,
    output logic [`DC_WORD_W-1:0]   value
);

    logic [7:0]            byte_val;
    logic [15:0]           half_val;
    logic [`DC_WORD_W-1:0] word_val;

    assign byte_val = line.bytes[offset];
    assign half_val = line.halves[offset[`DC_OFFSET_W-1:1]];
    assign word_val = line.words[offset[`DC_OFFSET_W-1]];

    always_comb begin
        case (size)
            BYTE: begin
                value = {{(`DC_WORD_W - 8){is_signed && byte_val[7]}}, byte_val};
            end
            HALF: begin
                value = {{(`DC_WORD_W - 16){is_signed && half_val[15]}}, half_val};
            end
            default: begin
                value = word_val;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/tree_plru.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

// Tree bits per set: [0] root, [1] picks within ways 0/1, [2] within ways 2/3.
// A set bit points to the upper half of its pair.
module tree_plru (
    input  logic                 clock,
    input  logic                 reset,
    input  logic [`DC_SET_W-1:0] lookup_set,
    output logic [`DC_WAY_W-1:0] victim_way,
    input  logic                 update_en,
    input  logic [`DC_SET_W-1:0] update_set,
    input  logic [`DC_WAY_W-1:0] update_way
);

    logic [2:0] tree [`DC_SETS];
    logic [2:0] node;

    assign node = tree[lookup_set];

    // Follow the pointers down to a leaf
    assign victim_way = node[0] ? {1'b1, node[2]} : {1'b0, node[1]};

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                tree[s] <= 3'b000;
            end
        end else if (update_en) begin
            // Point root and leaf pair away from the used way
            tree[update_set][0] <= ~update_way[1];
            if (update_way[1]) begin
                tree[update_set][2] <= ~update_way[0];
            end else begin
                tree[update_set][1] <= ~update_way[0];
            end
        end
    end

    a_update_way_known: assert property (
        @(posedge clock) disable iff (reset)
        update_en |-> !$isunknown(update_way)
    ) else $error("PLRU update with unknown way");

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/dcache_pkg.sv
design/tree_plru.sv
design/dcache_tag_array.sv
design/dcache_data_array.sv
design/load_align.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verification/dcache_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module dcache_tb -f project.f

output=$(./obj_dir/Vdcache_tb || true)
echo "$output"

echo "$output" | grep -q "^TESTS PASSED$"

//--- verification/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int WAIT_LIMIT = 40;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  req_valid;
    logic                  req_ready;
    logic                  req_store;
    logic [`DC_ADDR_W-1:0] req_addr;
    mem_size_t             req_size;
    logic                  req_signed;
    logic [`DC_WORD_W-1:0] req_data;
    logic                  resp_valid;
    logic [`DC_WORD_W-1:0] resp_data;
    logic                  mem_req_valid;
    logic                  mem_req_ready;
    logic                  mem_req_store;
    logic [`DC_ADDR_W-1:0] mem_req_addr;
    mem_size_t             mem_req_size;
    logic [`DC_WORD_W-1:0] mem_req_data;
    logic                  mem_resp_valid;
    logic [`DC_LINE_W-1:0] mem_resp_data;

    logic [7:0]           mem_model   [65536];
    logic                 model_valid [`DC_SETS][`DC_WAYS];
    logic [`DC_TAG_W-1:0] model_tag   [`DC_SETS][`DC_WAYS];
    logic [2:0]           model_tree  [`DC_SETS];

    logic [31:0] lcg_state = 32'd83;
    int          check_count = 0;
    int          error_count = 0;
    int          eviction_count = 0;
    logic        hung = 1'b0;

    dcache_top dut0 (
        .clock          (clock),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_store      (req_store),
        .req_addr       (req_addr),
        .req_size       (req_size),
        .req_signed     (req_signed),
        .req_data       (req_data),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_store  (mem_req_store),
        .mem_req_addr   (mem_req_addr),
        .mem_req_size   (mem_req_size),
        .mem_req_data   (mem_req_data),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data)
    );

    always #10 clock = ~clock;

    function automatic int rand_below(input int n);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[31:16]) % n;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [15:0] upper;
        upper = 16'(rand_below(65536));
        return {upper, 16'(rand_below(65536))};
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        hung = 1'b1;
        $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, WAIT_LIMIT);
    endtask

    // Invalid ways first, lowest number wins
    function automatic logic [1:0] pick_victim(input logic [2:0] set);
        logic [1:0] way;
        way = model_tree[set][0] ? {1'b1, model_tree[set][2]} : {1'b0, model_tree[set][1]};
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!model_valid[set][2'(w)]) begin
                way = 2'(w);
            end
        end
        return way;
    endfunction

    // Root and pair bits point at the half not just used
    function automatic void touch_tree(input logic [2:0] set, input logic [1:0] way);
        model_tree[set][0] = !way[1];
        if (way[1]) begin
            model_tree[set][2] = !way[0];
        end else begin
            model_tree[set][1] = !way[0];
        end
    endfunction

    function automatic logic model_access(input logic [15:0] addr, input logic is_store);
        logic [2:0] set;
        logic [1:0] way;
        logic       found;
        set = addr[5:3];
        way = 2'd0;
        found = 1'b0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (model_valid[set][2'(w)] && model_tag[set][2'(w)] == addr[15:6]) begin
                found = 1'b1;
                way = 2'(w);
            end
        end
        if (!found && !is_store) begin
            way = pick_victim(set);
            if (model_valid[set][way]) begin
                eviction_count++;
            end
            model_valid[set][way] = 1'b1;
            model_tag[set][way] = addr[15:6];
        end
        if (found || !is_store) begin
            touch_tree(set, way);
        end
        return found;
    endfunction

    // Little endian, byte 0 of a line in the low bits
    function automatic logic [31:0] expected_load(input logic [15:0] addr, input mem_size_t size,
                                                  input logic sgn);
        logic [31:0] raw;
        raw = {mem_model[addr + 16'd3], mem_model[addr + 16'd2],
               mem_model[addr + 16'd1], mem_model[addr]};
        case (size)
            BYTE:    return {{24{sgn & raw[7]}}, raw[7:0]};
            HALF:    return {{16{sgn & raw[15]}}, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    function automatic logic [63:0] line_from_memory(input logic [15:0] base);
        logic [63:0] line;
        line = '0;
        for (int i = 7; i >= 0; i--) begin
            line = {line[55:0], mem_model[base + 16'(i)]};
        end
        return line;
    endfunction

    function automatic void write_memory(input logic [15:0] addr, input mem_size_t size,
                                         input logic [31:0] data);
        logic [31:0] shifted;
        int          count;
        shifted = data;
        count = (size == BYTE) ? 1 : (size == HALF) ? 2 : 4;
        for (int i = 0; i < count; i++) begin
            mem_model[addr + 16'(i)] = shifted[7:0];
            shifted = shifted >> 8;
        end
    endfunction

    function automatic logic [15:0] make_addr(input int tag_index, input logic [2:0] set,
                                              input int offset, input mem_size_t size);
        logic [2:0] off;
        off = 3'(offset);
        if (size == HALF) begin
            off[0] = 1'b0;
        end
        if (size == WORD) begin
            off[1:0] = 2'b00;
        end
        return {10'(37 * tag_index + 11), set, off};
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic run_load(input logic [15:0] addr, input mem_size_t size, input logic sgn,
                            input int hold);
        logic        predicted_hit;
        logic [31:0] expected;
        logic [15:0] base;
        logic        done;
        int          waited;
        int          delay;
        predicted_hit = model_access(addr, 1'b0);
        expected = expected_load(addr, size, sgn);
        base = {addr[15:3], 3'b000};
        req_valid = 1'b1;
        req_store = 1'b0;
        req_addr = addr;
        req_size = size;
        req_signed = sgn;
        done = 1'b0;
        waited = 0;
        while (!done && !hung) begin
            @(negedge clock);
            check_value(32'(mem_req_valid), 32'd0, "memory request before load acceptance");
            done = req_ready;
            next_cycle();
            waited++;
            if (!done && waited >= WAIT_LIMIT) begin
                report_timeout("load acceptance");
            end
        end
        req_valid = 1'b0;
        if (!predicted_hit && !hung) begin
            done = 1'b0;
            waited = 0;
            while (!done && !hung) begin
                mem_req_ready = (waited >= hold) && (rand_below(4) != 0);
                @(negedge clock);
                check_value(32'({mem_req_valid, mem_req_store}), 32'b10, "line fetch request");
                check_value(32'(mem_req_addr), 32'(base), "line fetch address");
                check_value(32'(mem_req_size), 32'(DOUBLE), "line fetch size");
                check_value(32'({req_ready, resp_valid}), 32'd0, "handshake during fetch");
                done = mem_req_ready;
                next_cycle();
                waited++;
                if (!done && waited >= WAIT_LIMIT) begin
                    report_timeout("fetch transfer");
                end
            end
            mem_req_ready = 1'b0;
            // Memory answers 1 to 4 cycles after the fetch
            delay = 1 + rand_below(4);
            for (int c = 1; c <= delay; c++) begin
                mem_resp_valid = (c == delay);
                mem_resp_data = line_from_memory(base);
                @(negedge clock);
                check_value(32'(mem_req_valid), 32'd0, "memory request while line is pending");
                check_value(32'({req_ready, resp_valid}), 32'd0, "handshake while line is pending");
                next_cycle();
            end
            mem_resp_valid = 1'b0;
        end
        if (!hung) begin
            @(negedge clock);
            check_value(32'(resp_valid), 32'd1, "load response timing");
            check_value(resp_data, expected, "load data");
            check_value(32'(mem_req_valid), 32'd0, "memory request in response cycle");
            check_value(32'(req_ready), 32'd1, "req_ready in response cycle");
            next_cycle();
        end
    endtask

    task automatic run_store(input logic [15:0] addr, input mem_size_t size,
                             input logic [31:0] data, input int hold);
        logic done;
        int   waited;
        void'(model_access(addr, 1'b1));
        req_valid = 1'b1;
        req_store = 1'b1;
        req_addr = addr;
        req_size = size;
        req_data = data;
        done = 1'b0;
        waited = 0;
        while (!done && !hung) begin
            mem_req_ready = (waited >= hold) && (rand_below(4) != 0);
            @(negedge clock);
            check_value(32'({mem_req_valid, mem_req_store}), 32'b11, "write-through request");
            check_value(32'(mem_req_addr), 32'(addr), "write-through address");
            check_value(32'(mem_req_size), 32'(size), "write-through size");
            check_value(mem_req_data, data, "write-through data");
            check_value(32'(req_ready), 32'(mem_req_ready), "req_ready follows mem_req_ready");
            done = mem_req_ready;
            next_cycle();
            waited++;
            if (!done && waited >= WAIT_LIMIT) begin
                report_timeout("store transfer");
            end
        end
        req_valid = 1'b0;
        mem_req_ready = 1'b0;
        write_memory(addr, size, data);
    endtask

    // Six tags over sets 2 and 5
    task automatic run_random_op(input int hold);
        mem_size_t   size;
        logic [2:0]  set;
        logic [15:0] addr;
        int          tag_index;
        size = mem_size_t'(2'(rand_below(3)));
        set = (rand_below(2) != 0) ? 3'd2 : 3'd5;
        tag_index = rand_below(6);
        addr = make_addr(tag_index, set, rand_below(8), size);
        if (rand_below(10) < 3) begin
            run_store(addr, size, rand_word(), hold);
        end else begin
            run_load(addr, size, rand_below(2) != 0, hold);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s finished with %0d errors", name, error_count - errors_before);
    endtask

    initial begin
        int errors_before;
        reset = 1'b1;
        req_valid = 1'b0;
        req_store = 1'b0;
        req_addr = '0;
        req_size = BYTE;
        req_signed = 1'b0;
        req_data = '0;
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data = '0;
        for (int a = 0; a < 65536; a++) begin
            mem_model[16'(a)] = 8'(a * 7) ^ 8'(a >> 8) ^ 8'(a >> 13);
        end
        for (int s = 0; s < `DC_SETS; s++) begin
            model_tree[3'(s)] = 3'b000;
            for (int w = 0; w < `DC_WAYS; w++) begin
                model_valid[3'(s)][2'(w)] = 1'b0;
            end
        end
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        errors_before = error_count;
        @(negedge clock);
        check_value(32'({req_ready, resp_valid, mem_req_valid}), 32'b100, "outputs after reset");
        next_cycle();
        run_load(make_addr(0, 3'd2, 0, WORD), WORD, 1'b0, 0);
        report_test("reset", errors_before);

        errors_before = error_count;
        for (int o = 0; o < 8 && !hung; o++) begin
            run_load(make_addr(0, 3'd2, o, BYTE), BYTE, o[0], 0);
            run_load(make_addr(0, 3'd2, o, HALF), HALF, 1'b1, 0);
        end
        report_test("fill and hit", errors_before);

        // Six lines into one four-way set
        errors_before = error_count;
        for (int t = 0; t < 6 && !hung; t++) begin
            run_load(make_addr(t, 3'd5, t, WORD), WORD, 1'b0, 0);
        end
        for (int t = 5; t >= 0 && !hung; t--) begin
            run_load(make_addr(t, 3'd5, 0, HALF), HALF, 1'b1, 0);
        end
        report_test("replacement", errors_before);

        errors_before = error_count;
        for (int t = 0; t < 6 && !hung; t++) begin
            run_store(make_addr(t, 3'd5, 3, BYTE), BYTE, rand_word(), 0);
            run_load(make_addr(t, 3'd5, 2, HALF), HALF, 1'b0, 0);
        end
        report_test("store then load", errors_before);

        errors_before = error_count;
        for (int i = 0; i < 8 && !hung; i++) begin
            run_store(make_addr(i % 6, 3'd2, 4, WORD), WORD, rand_word(), 3);
            run_load(make_addr((i + 3) % 6, 3'd2, 0, WORD), WORD, 1'b0, 3);
        end
        report_test("back-pressure", errors_before);

        errors_before = error_count;
        for (int i = 0; i < 600 && !hung; i++) begin
            run_random_op((rand_below(4) == 0) ? rand_below(4) : 0);
        end
        report_test("random traffic", errors_before);

        $display("%0d checks, %0d errors, %0d evictions", check_count, error_count, eviction_count);
        if (hung || error_count != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire
